// ==== btn_events_if.sv ====
interface btn_events_if;

    logic press_start;   // Button 0
    logic press_lo;      // Button 1
    logic press_hi;      // Button 2
    logic press_mode;    // Button 3, steps the mode ring

    // One-cycle pulses, no acknowledge
    modport source (
        output press_start, press_lo, press_hi, press_mode
    );

    modport sink (
        input press_start, press_lo, press_hi, press_mode
    );

endinterface

// ==== build.f ====
clock_pkg.sv
btn_events_if.sv
button_sync.sv
time_base.sv
mode_control.sv
clock_watch.sv
cook_timer.sv
stop_watch.sv
fnd_display.sv
multi_watch_top.sv
multi_watch_asserts.sv
tb_multi_watch.sv

// ==== button_sync.sv ====
module button_sync (
    input  logic         clk,
    input  logic         reset_p,
    input  logic [3:0]   buttons,
    btn_events_if.source events
);

    logic [3:0] sync_q1;
    logic [3:0] sync_q2;
    logic [3:0] level_q;    // Synchronized level, one cycle old
    logic [3:0] press_q;

    // Two flops against metastability, then a registered rising edge
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            level_q <= '0;
            press_q <= '0;
        end else begin
            sync_q1 <= buttons;
            sync_q2 <= sync_q1;
            level_q <= sync_q2;
            press_q <= sync_q2 & ~level_q;   // High for one cycle per press
        end
    end

    assign events.press_start = press_q[0];
    assign events.press_lo    = press_q[1];
    assign events.press_hi    = press_q[2];
    assign events.press_mode  = press_q[3];

endmodule

// ==== clock_pkg.sv ====
package clock_pkg;

    // Mode ring, one-hot
    localparam int MODE_W = 3;
    localparam logic [MODE_W-1:0] MODE_WATCH = 3'b001;
    localparam logic [MODE_W-1:0] MODE_COOK  = 3'b010;
    localparam logic [MODE_W-1:0] MODE_STOP  = 3'b100;

    // Every displayed value fits 0 to 99
    localparam int VAL_W        = 7;
    localparam int SEC_MAX      = 59;     // Last second or minute
    localparam int CSEC_PER_SEC = 100;
    localparam int N_DIGITS     = 4;      // Digits on the board

    // ------------------------------------------------------------------
    // Display word

    typedef struct packed {
        logic [7:0] hi_bcd;               // Left digit pair
        logic [7:0] lo_bcd;               // Right digit pair
    } bcd_pair_t;

    // BCD converter fills the pair view, scanner picks single digits
    typedef union packed {
        bcd_pair_t                pair;
        logic [N_DIGITS-1:0][3:0] digit;  // digit[0] is the rightmost
    } fnd_word_t;

endpackage

// ==== clock_watch.sv ====
module clock_watch (
    input  logic                         clk,
    input  logic                         reset_p,
    input  logic                         sec_tick,
    input  logic                         clr_sec,
    input  logic                         inc_min,
    output logic [clock_pkg::VAL_W-1:0]  sec,
    output logic [clock_pkg::VAL_W-1:0]  min
);
    import clock_pkg::*;

    logic sec_wrap;   // Carry into the minutes

    assign sec_wrap = sec_tick && !clr_sec && (sec == VAL_W'(SEC_MAX));

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            sec <= '0;
        end else if (clr_sec) begin
            sec <= '0;                    // Sync to an outside reference
        end else if (sec_tick) begin
            if (sec == VAL_W'(SEC_MAX))
                sec <= '0;
            else
                sec <= sec + 1'b1;
        end
    end

    // Manual step and carry share one increment
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            min <= '0;
        end else if (inc_min || sec_wrap) begin
            if (min == VAL_W'(SEC_MAX))
                min <= '0;
            else
                min <= min + 1'b1;
        end
    end

endmodule

// ==== cook_timer.sv ====
module cook_timer (
    input  logic                         clk,
    input  logic                         reset_p,
    input  logic                         sec_tick,
    input  logic                         start,
    input  logic                         inc_sec,
    input  logic                         inc_min,
    input  logic                         alarm_off,
    output logic [clock_pkg::VAL_W-1:0]  sec,
    output logic [clock_pkg::VAL_W-1:0]  min,
    output logic                         alarm
);
    import clock_pkg::*;

    logic running;
    logic at_zero;
    logic tick_dec;    // Count down on this cycle
    logic hit_zero;    // Last second is expiring

    assign at_zero  = (min == '0) && (sec == '0);
    assign tick_dec = running && sec_tick && !start;
    assign hit_zero = tick_dec && (min == '0) && (sec == VAL_W'(1));

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            running <= 1'b0;
        end else if (start) begin
            running <= !running && !at_zero;   // Nothing to count from 00:00
        end else if (hit_zero) begin
            running <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            sec <= '0;
            min <= '0;
        end else if (tick_dec) begin
            if (sec == '0) begin
                sec <= VAL_W'(SEC_MAX);          // Borrow a minute
                min <= min - 1'b1;
            end else begin
                sec <= sec - 1'b1;
            end
        end else if (!running) begin
            // Setting keys only work while stopped
            if (inc_sec)
                sec <= (sec == VAL_W'(SEC_MAX)) ? '0 : sec + 1'b1;
            if (inc_min)
                min <= (min == VAL_W'(SEC_MAX)) ? '0 : min + 1'b1;
        end
    end

    // Alarm holds until the switch is raised
    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p)
            alarm <= 1'b0;
        else if (alarm_off)
            alarm <= 1'b0;
        else if (hit_zero)
            alarm <= 1'b1;
    end

endmodule

// ==== fnd_display.sv ====
module fnd_display #(
    parameter int SCAN_DIV = 100_000
) (
    input  logic                            clk,
    input  logic                            reset_p,
    input  logic [clock_pkg::MODE_W-1:0]    mode,
    input  logic [clock_pkg::VAL_W-1:0]     watch_sec,
    input  logic [clock_pkg::VAL_W-1:0]     watch_min,
    input  logic [clock_pkg::VAL_W-1:0]     cook_sec,
    input  logic [clock_pkg::VAL_W-1:0]     cook_min,
    input  logic [clock_pkg::VAL_W-1:0]     stop_sec,
    input  logic [clock_pkg::VAL_W-1:0]     stop_csec,
    output logic [7:0]                      seg,
    output logic [clock_pkg::N_DIGITS-1:0]  com
);
    import clock_pkg::*;

    localparam int SCAN_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam int IDX_W  = $clog2(N_DIGITS);

    logic [VAL_W-1:0]  hi_val;
    logic [VAL_W-1:0]  lo_val;
    fnd_word_t         word;
    logic [SCAN_W-1:0] scan_cnt;
    logic [IDX_W-1:0]  digit_idx;
    logic [3:0]        cur_digit;
    logic [6:0]        seg_on;      // Lit segments g..a, active high

    // Binary 0..99 to two BCD digits
    function automatic logic [7:0] to_bcd(input logic [VAL_W-1:0] v);
        logic [3:0] tens;
        logic [3:0] ones;
        tens = 4'(v / 10);
        ones = 4'(v % 10);
        return {tens, ones};
    endfunction

    always_comb begin
        case (mode)
            MODE_COOK: begin
                hi_val = cook_min;
                lo_val = cook_sec;
            end
            MODE_STOP: begin
                hi_val = stop_sec;
                lo_val = stop_csec;
            end
            default: begin
                hi_val = watch_min;
                lo_val = watch_sec;
            end
        endcase
    end

    always_comb begin
        word.pair.hi_bcd = to_bcd(hi_val);
        word.pair.lo_bcd = to_bcd(lo_val);
    end

    // ------------------------------------------------------------------
    // Digit scan

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == SCAN_W'(SCAN_DIV - 1)) begin
            scan_cnt  <= '0;
            digit_idx <= (digit_idx == IDX_W'(N_DIGITS - 1)) ? '0 : digit_idx + 1'b1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign cur_digit = word.digit[digit_idx];

    always_comb begin
        case (cur_digit)
            4'd0:    seg_on = 7'b011_1111;
            4'd1:    seg_on = 7'b000_0110;
            4'd2:    seg_on = 7'b101_1011;
            4'd3:    seg_on = 7'b100_1111;
            4'd4:    seg_on = 7'b110_0110;
            4'd5:    seg_on = 7'b110_1101;
            4'd6:    seg_on = 7'b111_1101;
            4'd7:    seg_on = 7'b000_0111;
            4'd8:    seg_on = 7'b111_1111;
            4'd9:    seg_on = 7'b110_1111;
            default: seg_on = 7'b000_0000;   // Blank
        endcase
    end

    assign seg = {1'b1, ~seg_on};                     // Decimal point off
    assign com = ~(N_DIGITS'(1) << digit_idx);        // Active low select

endmodule

// ==== mode_control.sv ====
module mode_control (
    input  logic                          clk,
    input  logic                          reset_p,
    btn_events_if.sink                    events,
    output logic [clock_pkg::MODE_W-1:0]  mode,
    output logic                          watch_start,
    output logic                          watch_lo,
    output logic                          watch_hi,
    output logic                          cook_start,
    output logic                          cook_lo,
    output logic                          cook_hi,
    output logic                          stop_start,
    output logic                          stop_lo,
    output logic                          stop_hi
);
    import clock_pkg::*;

    logic [MODE_W-1:0] next_mode;
    logic              is_watch;
    logic              is_cook;
    logic              is_stop;

    // Watch -> cook timer -> stopwatch -> watch
    always_comb begin
        case (mode)
            MODE_WATCH: next_mode = MODE_COOK;
            MODE_COOK:  next_mode = MODE_STOP;
            default:    next_mode = MODE_WATCH;
        endcase
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            mode <= MODE_WATCH;
        end else if (events.press_mode) begin
            mode <= next_mode;
        end
    end

    assign is_watch = (mode == MODE_WATCH);
    assign is_cook  = (mode == MODE_COOK);
    assign is_stop  = (mode == MODE_STOP);

    // Only the active unit sees buttons 0 to 2
    assign watch_start = events.press_start & is_watch;
    assign watch_lo    = events.press_lo    & is_watch;
    assign watch_hi    = events.press_hi    & is_watch;
    assign cook_start  = events.press_start & is_cook;
    assign cook_lo     = events.press_lo    & is_cook;
    assign cook_hi     = events.press_hi    & is_cook;
    assign stop_start  = events.press_start & is_stop;
    assign stop_lo     = events.press_lo    & is_stop;
    assign stop_hi     = events.press_hi    & is_stop;

endmodule

// ==== multi_watch_asserts.sv ====
module multi_watch_asserts (
    input logic                          clk,
    input logic                          reset_p,
    input logic [clock_pkg::MODE_W-1:0]  mode,
    input logic                          watch_start,
    input logic                          watch_lo,
    input logic                          watch_hi,
    input logic                          cook_start,
    input logic                          cook_lo,
    input logic                          cook_hi,
    input logic                          stop_start,
    input logic                          stop_lo,
    input logic                          stop_hi
);
    import clock_pkg::*;

    logic [2:0] group_active;   // One bit per routed unit

    assign group_active = {|{stop_start, stop_lo, stop_hi},
                           |{cook_start, cook_lo, cook_hi},
                           |{watch_start, watch_lo, watch_hi}};

    mode_onehot: assert property (@(posedge clk) disable iff (reset_p) $onehot(mode))
        else $error("mode %b is not one-hot", mode);

    // Buttons reach one unit only
    route_single: assert property (@(posedge clk) disable iff (reset_p)
                                   $onehot0(group_active))
        else $error("press routed to more than one unit: %b", group_active);

    reset_to_watch: assert property (@(posedge clk) $fell(reset_p) |-> mode == MODE_WATCH)
        else $error("mode %b after reset, watch mode expected", mode);

endmodule

bind mode_control multi_watch_asserts u_mode_asserts (
    .clk         (clk),
    .reset_p     (reset_p),
    .mode        (mode),
    .watch_start (watch_start),
    .watch_lo    (watch_lo),
    .watch_hi    (watch_hi),
    .cook_start  (cook_start),
    .cook_lo     (cook_lo),
    .cook_hi     (cook_hi),
    .stop_start  (stop_start),
    .stop_lo     (stop_lo),
    .stop_hi     (stop_hi)
);

// ==== multi_watch_top.sv ====
module multi_watch_top #(
    parameter int CLKS_PER_CSEC = 1_000_000,
    parameter int SCAN_DIV      = 100_000
) (
    input  logic        clk,
    input  logic        reset_p,
    input  logic [3:0]  button,
    input  logic        alarm_off,
    output logic [7:0]  seg,
    output logic [3:0]  com,
    output logic [15:0] led,
    output logic        buz
);
    import clock_pkg::*;

    logic              csec_tick;
    logic              sec_tick;
    logic [MODE_W-1:0] mode;
    logic              watch_start;
    logic              watch_hi;
    logic              cook_start;
    logic              cook_lo;
    logic              cook_hi;
    logic              stop_start;
    logic              stop_lo;
    logic              stop_hi;
    logic [VAL_W-1:0]  watch_sec;
    logic [VAL_W-1:0]  watch_min;
    logic [VAL_W-1:0]  cook_sec;
    logic [VAL_W-1:0]  cook_min;
    logic [VAL_W-1:0]  stop_sec;
    logic [VAL_W-1:0]  stop_csec;
    logic              stop_running;
    logic              stop_lap;
    logic              alarm;

    // ------------------------------------------------------------------
    // Buttons and timing

    btn_events_if events_bus ();

    button_sync u_button_sync (
        .clk     (clk),
        .reset_p (reset_p),
        .buttons (button),
        .events  (events_bus.source)
    );

    time_base #(.CLKS_PER_CSEC(CLKS_PER_CSEC)) u_time_base (
        .clk       (clk),
        .reset_p   (reset_p),
        .csec_tick (csec_tick),
        .sec_tick  (sec_tick)
    );

    mode_control u_mode_control (
        .clk         (clk),
        .reset_p     (reset_p),
        .events      (events_bus.sink),
        .mode        (mode),
        .watch_start (watch_start),
        .watch_lo    (),                 // Button 1 has no job in watch mode
        .watch_hi    (watch_hi),
        .cook_start  (cook_start),
        .cook_lo     (cook_lo),
        .cook_hi     (cook_hi),
        .stop_start  (stop_start),
        .stop_lo     (stop_lo),
        .stop_hi     (stop_hi)
    );

    // ------------------------------------------------------------------
    // Timekeeping units, all running in every mode

    clock_watch u_clock_watch (
        .clk      (clk),
        .reset_p  (reset_p),
        .sec_tick (sec_tick),
        .clr_sec  (watch_start),
        .inc_min  (watch_hi),
        .sec      (watch_sec),
        .min      (watch_min)
    );

    cook_timer u_cook_timer (
        .clk       (clk),
        .reset_p   (reset_p),
        .sec_tick  (sec_tick),
        .start     (cook_start),
        .inc_sec   (cook_lo),
        .inc_min   (cook_hi),
        .alarm_off (alarm_off),
        .sec       (cook_sec),
        .min       (cook_min),
        .alarm     (alarm)
    );

    stop_watch u_stop_watch (
        .clk        (clk),
        .reset_p    (reset_p),
        .csec_tick  (csec_tick),
        .start      (stop_start),
        .lap_toggle (stop_lo),
        .clear      (stop_hi),
        .sec        (stop_sec),
        .csec       (stop_csec),
        .running    (stop_running),
        .lap        (stop_lap)
    );

    // ------------------------------------------------------------------
    // Display and status lights

    fnd_display #(.SCAN_DIV(SCAN_DIV)) u_fnd_display (
        .clk       (clk),
        .reset_p   (reset_p),
        .mode      (mode),
        .watch_sec (watch_sec),
        .watch_min (watch_min),
        .cook_sec  (cook_sec),
        .cook_min  (cook_min),
        .stop_sec  (stop_sec),
        .stop_csec (stop_csec),
        .seg       (seg),
        .com       (com)
    );

    // Alarm on led[15], mode on led[7:5], stopwatch state on led[1:0]
    assign led = {alarm, 7'd0, mode, 3'd0, stop_lap, stop_running};
    assign buz = alarm;

endmodule

// ==== stop_watch.sv ====
module stop_watch (
    input  logic                         clk,
    input  logic                         reset_p,
    input  logic                         csec_tick,
    input  logic                         start,
    input  logic                         lap_toggle,
    input  logic                         clear,
    output logic [clock_pkg::VAL_W-1:0]  sec,
    output logic [clock_pkg::VAL_W-1:0]  csec,
    output logic                         running,
    output logic                         lap
);
    import clock_pkg::*;

    logic [VAL_W-1:0] cnt_sec;
    logic [VAL_W-1:0] cnt_csec;
    logic [VAL_W-1:0] lap_sec;      // Frozen copy for lap view
    logic [VAL_W-1:0] lap_csec;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            running <= 1'b0;
            lap     <= 1'b0;
        end else if (clear) begin
            running <= 1'b0;
            lap     <= 1'b0;
        end else begin
            if (start)
                running <= !running;
            if (lap_toggle)
                lap <= !lap;
        end
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            cnt_sec  <= '0;
            cnt_csec <= '0;
        end else if (clear) begin
            cnt_sec  <= '0;
            cnt_csec <= '0;
        end else if (running && csec_tick) begin
            if (cnt_csec == VAL_W'(CSEC_PER_SEC - 1)) begin
                cnt_csec <= '0;
                cnt_sec  <= (cnt_sec == VAL_W'(SEC_MAX)) ? '0 : cnt_sec + 1'b1;
            end else begin
                cnt_csec <= cnt_csec + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            lap_sec  <= '0;
            lap_csec <= '0;
        end else if (clear) begin
            lap_sec  <= '0;
            lap_csec <= '0;
        end else if (lap_toggle) begin
            lap_sec  <= cnt_sec;
            lap_csec <= cnt_csec;
        end
    end

    // Count keeps running underneath the lap view
    assign sec  = lap ? lap_sec  : cnt_sec;
    assign csec = lap ? lap_csec : cnt_csec;

endmodule

// ==== tb_multi_watch.sv ====
module tb_multi_watch;

    localparam int CLKS_PER_CSEC = 4;
    localparam int SCAN_DIV      = 8;

    logic        clk;
    logic        reset_p;
    logic [3:0]  button;
    logic        alarm_off;
    logic [7:0]  seg;
    logic [3:0]  com;
    logic [15:0] led;
    logic        buz;

    int seed = 32'h5afd_f7de;
    int cycle;
    int errors;
    int checks;
    int tests;
    int test_errors;
    int mode_idx;       // Model mode, 0 watch, 1 cook, 2 stopwatch
    int cook_sec;
    int cook_min;
    int watch_min;

    multi_watch_top #(
        .CLKS_PER_CSEC (CLKS_PER_CSEC),
        .SCAN_DIV      (SCAN_DIV)
    ) UUT (
        .clk       (clk),
        .reset_p   (reset_p),
        .button    (button),
        .alarm_off (alarm_off),
        .seg       (seg),
        .com       (com),
        .led       (led),
        .buz       (buz)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Lit segments gfedcba to a digit, -1 for anything else
    function automatic int seg_digit(input logic [6:0] lit);
        case (lit)
            7'h3f:   return 0;
            7'h06:   return 1;
            7'h5b:   return 2;
            7'h4f:   return 3;
            7'h66:   return 4;
            7'h6d:   return 5;
            7'h7d:   return 6;
            7'h07:   return 7;
            7'h7f:   return 8;
            7'h6f:   return 9;
            default: return -1;
        endcase
    endfunction

    task automatic check(input string name, input int expected, input int actual);
        checks++;
        assert (actual == expected) else begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    // Button held 4 cycles, then released for a random gap
    task automatic press(input int b);
        int gap;
        gap = 3 + rand_below(6);
        @(posedge clk);
        #2 button[b] = 1'b1;
        repeat (4) @(posedge clk);
        #2 button[b] = 1'b0;
        repeat (gap) @(posedge clk);
        #2;
    endtask

    task automatic goto_mode(input int target);
        while (mode_idx != target) begin
            press(3);
            mode_idx = (mode_idx + 1) % 3;
            check("mode ring", 1 << mode_idx, led[7:5]);
        end
    endtask

    // ------------------------------------------------------------------
    // Display reading

    task automatic read_digit(input int idx, output int d);
        logic [3:0] sel;
        int         wait_cnt;
        sel      = ~(4'b0001 << idx);
        wait_cnt = 0;
        d        = -1;
        @(negedge clk);
        while (com != sel && wait_cnt < 64) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (com != sel) begin
            $display("Timed out waiting for display digit %0d to be selected", idx);
            errors++;
        end else begin
            d = seg_digit(~seg[6:0]);
            check("decimal point off", 1, seg[7]);
        end
    endtask

    task automatic read_display(output int hi, output int lo);
        int d3;
        int d2;
        int d1;
        int d0;
        read_digit(3, d3);
        read_digit(2, d2);
        read_digit(1, d1);
        read_digit(0, d0);
        hi = d3 * 10 + d2;
        lo = d1 * 10 + d0;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors)
            $display("Test %0d %s: ok", tests, name);
        else
            $display("Test %0d %s: %0d errors", tests, name, errors - test_errors);
        test_errors = errors;
    endtask

    // ------------------------------------------------------------------
    // Test sequence

    initial begin
        int hi;
        int lo;
        int hi2;
        int lo2;
        int n;
        int t0;
        int elapsed;
        clk       = 1'b0;
        reset_p   = 1'b1;
        button    = 4'b0000;
        alarm_off = 1'b0;
        cycle       = 0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        test_errors = 0;
        mode_idx    = 0;
        cook_sec    = 0;
        cook_min    = 0;
        watch_min   = 0;
        repeat (8) @(posedge clk);
        #2 reset_p = 1'b0;

        check("reset mode", 1, led[7:5]);
        check("reset status", 0, {led[15], led[1:0], buz});
        check("unused leds", 0, {led[14:8], led[4:2]});
        n = 1 + rand_below(8);
        repeat (n) begin
            press(3);
            mode_idx = (mode_idx + 1) % 3;
            check("mode ring", 1 << mode_idx, led[7:5]);
        end
        end_test("mode ring");

        goto_mode(1);
        n = 50 + rand_below(20);          // Sometimes past 59
        repeat (n) press(1);
        cook_sec = n % 60;
        n = 58 + rand_below(4);
        repeat (n) press(2);
        cook_min = n % 60;
        read_display(hi, lo);
        check("cook minutes", cook_min, hi);
        check("cook seconds", cook_sec, lo);
        goto_mode(2);
        n = 1 + rand_below(4);
        repeat (n) press(1 + rand_below(2));
        press(2);                          // Leaves the stopwatch cleared
        goto_mode(1);
        read_display(hi, lo);
        check("cook minutes kept", cook_min, hi);
        check("cook seconds kept", cook_sec, lo);
        end_test("cook setting");

        repeat ((60 - cook_min) % 60) press(2);
        repeat ((62 - cook_sec) % 60) press(1);
        cook_min = 0;
        cook_sec = 2;
        read_display(hi, lo);
        check("cook short time", cook_min * 100 + cook_sec, hi * 100 + lo);
        press(0);
        n = 0;
        while (!buz && n < 4000) begin
            @(negedge clk);
            n++;
        end
        if (!buz) begin
            $display("Timed out waiting for the cook timer alarm");
            errors++;
        end
        read_display(hi, lo);
        check("cook at zero", 0, hi * 100 + lo);
        check("alarm led", 1, led[15]);
        check("unused leds", 0, {led[14:8], led[4:2]});
        @(posedge clk);
        #2 alarm_off = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        check("alarm off", 0, buz);
        alarm_off = 1'b0;
        end_test("cook alarm");

        goto_mode(2);
        t0 = cycle;
        press(0);
        check("running led", 1, led[0]);
        repeat (20 + rand_below(120)) @(posedge clk);
        #2;
        elapsed = cycle - t0;              // Start and stop see equal latency
        press(0);
        check("stopped led", 0, led[0]);
        read_display(hi, lo);
        n = hi * 100 + lo;
        checks++;
        assert (n >= elapsed / CLKS_PER_CSEC - 1 && n <= elapsed / CLKS_PER_CSEC + 1) else begin
            $display("[ERROR] stopwatch time: expected %0d +/- 1, actual %0d",
                     elapsed / CLKS_PER_CSEC, n);
            errors++;
        end
        end_test("stopwatch run");

        press(0);
        check("running again", 1, led[0]);
        repeat (10 + rand_below(40)) @(posedge clk);
        press(1);
        check("lap led", 1, led[1]);
        read_display(hi, lo);
        read_display(hi2, lo2);
        check("lap frozen", hi * 100 + lo, hi2 * 100 + lo2);
        press(2);
        read_display(hi, lo);
        check("cleared display", 0, hi * 100 + lo);
        check("cleared leds", 0, led[1:0]);
        end_test("lap and clear");

        goto_mode(0);
        press(0);
        read_display(hi, lo);
        checks++;
        assert (lo <= 1) else begin
            $display("[ERROR] watch seconds after clear: expected at most 1, actual %0d", lo);
            errors++;
        end
        check("watch minutes before adjust", watch_min, hi);
        n = rand_below(70);
        repeat (n) press(2);
        watch_min = (watch_min + n) % 60;
        read_display(hi, lo);
        check("watch minutes", watch_min, hi);
        end_test("watch adjust");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== time_base.sv ====
module time_base #(
    parameter int CLKS_PER_CSEC = 1_000_000
) (
    input  logic clk,
    input  logic reset_p,
    output logic csec_tick,
    output logic sec_tick
);
    import clock_pkg::*;

    localparam int CYC_W  = (CLKS_PER_CSEC > 1) ? $clog2(CLKS_PER_CSEC) : 1;
    localparam int CSEC_W = $clog2(CSEC_PER_SEC);

    logic [CYC_W-1:0]  cyc_cnt;
    logic [CSEC_W-1:0] csec_cnt;

    always_ff @(posedge clk or posedge reset_p) begin
        if (reset_p) begin
            cyc_cnt   <= '0;
            csec_cnt  <= '0;
            csec_tick <= 1'b0;
            sec_tick  <= 1'b0;
        end else begin
            csec_tick <= 1'b0;
            sec_tick  <= 1'b0;
            if (cyc_cnt == CYC_W'(CLKS_PER_CSEC - 1)) begin
                cyc_cnt   <= '0;
                csec_tick <= 1'b1;
                // Every hundredth centisecond also marks a second
                if (csec_cnt == CSEC_W'(CSEC_PER_SEC - 1)) begin
                    csec_cnt <= '0;
                    sec_tick <= 1'b1;
                end else begin
                    csec_cnt <= csec_cnt + 1'b1;
                end
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

endmodule
